/* filelist.f */
mem_ops_pkg.sv
line_cfg_pkg.sv
req_sequencer.sv
mem_ctrl.sv
host_dma_port.sv
resp_assembler.sv
mem_subsys_top.sv
tb_clock_gen.sv
tb_mem_subsys.sv

/* host_dma_port.sv */
`timescale 1ns/1ns

module host_dma_port #(
	parameter int LINE_SIZE = line_cfg_pkg::DEF_LINE_SIZE,
	parameter int ADDR_BITS = line_cfg_pkg::DEF_ADDR_BITS
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 host_rgo,
	input  logic                 host_wgo,
	input  logic                 host_we,
	input  logic [ADDR_BITS-1:0] head_addr,
	input  logic [LINE_SIZE-1:0] host_wr_line,
	output logic                 host_rd_ready,
	output logic [LINE_SIZE-1:0] host_rd_line,
	output logic                 host_wr_ready,
	output logic                 mem_rd_req,
	output logic [ADDR_BITS-1:0] mem_addr,
	input  logic                 mem_rd_valid,
	input  logic [LINE_SIZE-1:0] mem_rd_data,
	input  logic                 mem_wr_ready,
	output logic                 mem_wr_en,
	output logic [LINE_SIZE-1:0] mem_wr_data
);
	// Request sent and data not yet back
	logic rd_pending;
	// Line captured and held until the controller leaves HOSTOP
	logic rd_ready_q;
	logic rd_return;

	assign rd_return     = rd_pending && mem_rd_valid;
	// One request per HOSTOP read
	assign mem_rd_req    = host_rgo && !rd_pending && !rd_ready_q;
	assign mem_addr      = head_addr;
	assign host_rd_ready = rd_ready_q;

	// Write side passes straight through while a write is in progress
	assign host_wr_ready = host_wgo && mem_wr_ready;
	assign mem_wr_en     = host_wgo && host_we;
	assign mem_wr_data   = host_wr_line;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_pending <= 1'b0;
			rd_ready_q <= 1'b0;
		end else begin
			if (mem_rd_req) begin
				rd_pending <= 1'b1;
			end else if (mem_rd_valid) begin
				rd_pending <= 1'b0;
			end
			if (rd_return) begin
				rd_ready_q <= 1'b1;
			end else if (!host_rgo) begin
				rd_ready_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_return) begin
			host_rd_line <= mem_rd_data;
		end
	end

	// Only one host read outstanding until its data returns
	a_one_rd_pending: assert property (@(posedge clk) disable iff (!rst_n)
		mem_rd_req |=> !mem_rd_req until_with mem_rd_valid);

endmodule

/* line_cfg_pkg.sv */
package line_cfg_pkg;

	// Cache word width in bits
	parameter int DEF_WORD_SIZE = 32;

	// Cache line width in bits
	// Four words per line with the default word width
	parameter int DEF_LINE_SIZE = 128;

	// Line address width
	parameter int DEF_ADDR_BITS = 32;

	// Entries in the request queue
	parameter int DEF_QUEUE_DEPTH = 4;

endpackage

/* mem_ctrl.sv */
`timescale 1ns/1ns

module mem_ctrl #(
	parameter int WORD_SIZE = line_cfg_pkg::DEF_WORD_SIZE,
	parameter int LINE_SIZE = line_cfg_pkg::DEF_LINE_SIZE
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   host_init,
	input  logic                   host_rd_ready,
	input  logic                   host_wr_ready,
	input  mem_ops_pkg::mem_opcode op,
	input  logic [WORD_SIZE-1:0]   wr_word,
	output logic [WORD_SIZE-1:0]   rd_word,
	input  logic [LINE_SIZE-1:0]   host_rd_line,
	output logic [LINE_SIZE-1:0]   host_wr_line,
	output logic                   ready,
	output logic                   tx_done,
	output logic                   rd_valid,
	output logic                   host_we,
	output logic                   host_rgo,
	output logic                   host_wgo
);
	import mem_ops_pkg::*;

	localparam int WORDS    = LINE_SIZE / WORD_SIZE;
	localparam int CNT_BITS = (WORDS > 1) ? $clog2(WORDS) : 1;

	ctrl_state            state;
	logic [CNT_BITS-1:0]  fill_count;
	logic [LINE_SIZE-1:0] line_buffer;
	// Host DMA needs one idle cycle after write ready before the strobe
	logic                 bubble;
	logic                 fill_last;

	assign fill_last    = (fill_count == CNT_BITS'(WORDS - 1));
	assign host_wr_line = line_buffer;
	// Drain word selected by the fill counter
	assign rd_word      = line_buffer[fill_count*WORD_SIZE +: WORD_SIZE];

	always_comb begin
		ready    = (state != STARTUP);
		tx_done  = 1'b0;
		rd_valid = 1'b0;
		host_we  = 1'b0;
		host_rgo = 1'b0;
		host_wgo = 1'b0;
		case (state)
			HOSTOP: begin
				if (op == WRITE) begin
					host_wgo = 1'b1;
					// Strobe after ready held through the bubble
					if (bubble && host_wr_ready) begin
						host_we = 1'b1;
						tx_done = 1'b1;
					end
				end else if (op == READ) begin
					host_rgo = 1'b1;
				end
			end
			FILL: begin
				// Read drain puts out one word per cycle
				if (op == READ) begin
					rd_valid = 1'b1;
					tx_done  = fill_last;
				end
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= STARTUP;
			fill_count <= '0;
			bubble     <= 1'b0;
		end else begin
			case (state)
				STARTUP: begin
					// Nothing is served until host memory is up
					if (host_init) begin
						state <= READY;
					end
				end
				READY: begin
					// Reads go to the host first and writes gather words first
					if (op == READ) begin
						state <= HOSTOP;
					end else if (op == WRITE) begin
						state <= FILL;
					end
				end
				FILL: begin
					if (fill_last) begin
						fill_count <= '0;
						if (op == WRITE) begin
							state <= HOSTOP;
						end else begin
							state <= READY;
						end
					end else begin
						fill_count <= fill_count + 1'b1;
					end
				end
				HOSTOP: begin
					if (op == READ) begin
						if (host_rd_ready) begin
							state <= FILL;
						end
					end else if (op == WRITE) begin
						if (bubble && host_wr_ready) begin
							state  <= READY;
							bubble <= 1'b0;
						end else begin
							// Bubble follows ready so a dropped ready restarts the wait
							bubble <= host_wr_ready;
						end
					end else begin
						state <= READY;
					end
				end
				default: begin
					state <= STARTUP;
				end
			endcase
		end
	end

	// Line buffer
	always_ff @(posedge clk) begin
		if (state == FILL && op == WRITE) begin
			// Shift in from the top so word 0 ends in the low bits
			line_buffer <= {wr_word, line_buffer[LINE_SIZE-1:WORD_SIZE]};
		end else if (state == HOSTOP && op == READ && host_rd_ready) begin
			line_buffer <= host_rd_line;
		end
	end

	// Completion only while the sequencer still holds the same request
	a_done_has_op: assert property (@(posedge clk) disable iff (!rst_n)
		tx_done |-> op != IDLE && $stable(op));

	// Write strobe needs ready in the bubble cycle and in the strobe cycle
	a_we_after_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		host_we |-> host_wr_ready && $past(host_wr_ready));

endmodule

/* mem_ops_pkg.sv */
package mem_ops_pkg;

	// Cache miss opcodes as carried on the request queue and the controller op input
	// Encoding follows the cache side message type
	typedef enum logic [1:0] {
		IDLE  = 2'b00,
		READ  = 2'b01,
		WRITE = 2'b11
	} mem_opcode;

	// Line-buffer controller states
	// STARTUP holds until the host memory reports init
	// READY dispatches on the presented op
	// HOSTOP waits on the host bus for a line read or a line write
	// FILL moves words between the cache side and the line buffer
	typedef enum logic [1:0] {
		STARTUP = 2'b00,
		READY   = 2'b01,
		HOSTOP  = 2'b10,
		FILL    = 2'b11
	} ctrl_state;

endpackage

/* mem_subsys_top.sv */
`timescale 1ns/1ns

module mem_subsys_top #(
	parameter int WORD_SIZE   = line_cfg_pkg::DEF_WORD_SIZE,
	parameter int LINE_SIZE   = line_cfg_pkg::DEF_LINE_SIZE,
	parameter int ADDR_BITS   = line_cfg_pkg::DEF_ADDR_BITS,
	parameter int QUEUE_DEPTH = line_cfg_pkg::DEF_QUEUE_DEPTH
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   mem_init,
	// Cache request side
	input  logic                   req_push,
	input  mem_ops_pkg::mem_opcode req_op,
	input  logic [ADDR_BITS-1:0]   req_addr,
	input  logic [LINE_SIZE-1:0]   req_wline,
	output logic                   req_full,
	// Cache response side
	output logic                   resp_valid,
	output logic [ADDR_BITS-1:0]   resp_addr,
	output logic [LINE_SIZE-1:0]   resp_line,
	// Host memory bus
	output logic                   mem_rd_req,
	output logic [ADDR_BITS-1:0]   mem_addr,
	input  logic                   mem_rd_valid,
	input  logic [LINE_SIZE-1:0]   mem_rd_data,
	input  logic                   mem_wr_ready,
	output logic                   mem_wr_en,
	output logic [LINE_SIZE-1:0]   mem_wr_data
);
	import mem_ops_pkg::*;

	// Sequencer to controller
	mem_opcode            op;
	logic [ADDR_BITS-1:0] head_addr;
	logic [WORD_SIZE-1:0] wr_word;
	logic                 ready;
	logic                 tx_done;
	// Controller drain
	logic                 rd_valid;
	logic [WORD_SIZE-1:0] rd_word;
	// Controller to host port
	logic                 host_rgo;
	logic                 host_wgo;
	logic                 host_we;
	logic                 host_rd_ready;
	logic                 host_wr_ready;
	logic [LINE_SIZE-1:0] host_rd_line;
	logic [LINE_SIZE-1:0] host_wr_line;

	req_sequencer #(
		.WORD_SIZE(WORD_SIZE), .LINE_SIZE(LINE_SIZE),
		.ADDR_BITS(ADDR_BITS), .QUEUE_DEPTH(QUEUE_DEPTH)
	) req_sequencer_inst (
		.clk(clk), .rst_n(rst_n), .req_push(req_push), .req_op(req_op),
		.req_addr(req_addr), .req_wline(req_wline), .req_full(req_full),
		.ready(ready), .tx_done(tx_done), .op(op), .head_addr(head_addr),
		.wr_word(wr_word)
	);

	mem_ctrl #(.WORD_SIZE(WORD_SIZE), .LINE_SIZE(LINE_SIZE)) mem_ctrl_inst (
		.clk(clk), .rst_n(rst_n), .host_init(mem_init),
		.host_rd_ready(host_rd_ready), .host_wr_ready(host_wr_ready),
		.op(op), .wr_word(wr_word), .rd_word(rd_word),
		.host_rd_line(host_rd_line), .host_wr_line(host_wr_line),
		.ready(ready), .tx_done(tx_done), .rd_valid(rd_valid),
		.host_we(host_we), .host_rgo(host_rgo), .host_wgo(host_wgo)
	);

	host_dma_port #(.LINE_SIZE(LINE_SIZE), .ADDR_BITS(ADDR_BITS)) host_dma_port_inst (
		.clk(clk), .rst_n(rst_n), .host_rgo(host_rgo), .host_wgo(host_wgo),
		.host_we(host_we), .head_addr(head_addr), .host_wr_line(host_wr_line),
		.host_rd_ready(host_rd_ready), .host_rd_line(host_rd_line),
		.host_wr_ready(host_wr_ready), .mem_rd_req(mem_rd_req), .mem_addr(mem_addr),
		.mem_rd_valid(mem_rd_valid), .mem_rd_data(mem_rd_data),
		.mem_wr_ready(mem_wr_ready), .mem_wr_en(mem_wr_en), .mem_wr_data(mem_wr_data)
	);

	resp_assembler #(
		.WORD_SIZE(WORD_SIZE), .LINE_SIZE(LINE_SIZE), .ADDR_BITS(ADDR_BITS)
	) resp_assembler_inst (
		.clk(clk), .rst_n(rst_n), .rd_valid(rd_valid), .tx_done(tx_done),
		.rd_word(rd_word), .head_addr(head_addr), .resp_valid(resp_valid),
		.resp_addr(resp_addr), .resp_line(resp_line)
	);

endmodule

/* mem_subsys_trace.txt */
# op line_address line_value in hex with word 0 in the low bits
# W lines carry write data and R lines carry the expected read line
# first four are queued before mem_init
W 00000010 d3d2d1d0c3c2c1c0b3b2b1b0a3a2a1a0
R 00000020 00000020000000200000002000000020
R 00000010 d3d2d1d0c3c2c1c0b3b2b1b0a3a2a1a0
W 00000030 11112222333344445555666677778888
# served after mem_init
R 00000030 11112222333344445555666677778888
W 00000010 0f0e0d0c0b0a09080706050403020100
R 00000010 0f0e0d0c0b0a09080706050403020100
R 12345678 12345678123456781234567812345678
W 12345678 deadbeefcafef00d0123456789abcdef
W 00000040 44444444333333332222222211111111
R 12345678 deadbeefcafef00d0123456789abcdef
R 00000040 44444444333333332222222211111111
R ffffffc0 ffffffc0ffffffc0ffffffc0ffffffc0
W ffffffc0 8000000040000000200000001000000f
R ffffffc0 8000000040000000200000001000000f
R 00000030 11112222333344445555666677778888
W 00000050 aaaaaaaa55555555aaaaaaaa55555555
W 00000060 00000004000000030000000200000001
R 00000050 aaaaaaaa55555555aaaaaaaa55555555
R 00000060 00000004000000030000000200000001
W 00000020 13579bdf2468ace0fedcba9876543210
R 00000020 13579bdf2468ace0fedcba9876543210
R 00000070 00000070000000700000007000000070

/* req_sequencer.sv */
`timescale 1ns/1ns

module req_sequencer #(
	parameter int WORD_SIZE   = line_cfg_pkg::DEF_WORD_SIZE,
	parameter int LINE_SIZE   = line_cfg_pkg::DEF_LINE_SIZE,
	parameter int ADDR_BITS   = line_cfg_pkg::DEF_ADDR_BITS,
	parameter int QUEUE_DEPTH = line_cfg_pkg::DEF_QUEUE_DEPTH
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   req_push,
	input  mem_ops_pkg::mem_opcode req_op,
	input  logic [ADDR_BITS-1:0]   req_addr,
	input  logic [LINE_SIZE-1:0]   req_wline,
	output logic                   req_full,
	input  logic                   ready,
	input  logic                   tx_done,
	output mem_ops_pkg::mem_opcode op,
	output logic [ADDR_BITS-1:0]   head_addr,
	output logic [WORD_SIZE-1:0]   wr_word
);
	import mem_ops_pkg::*;

	localparam int WORDS    = LINE_SIZE / WORD_SIZE;
	localparam int IDX_BITS = (WORDS > 1) ? $clog2(WORDS) : 1;
	localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

	// Queue storage
	mem_opcode            op_q   [QUEUE_DEPTH];
	logic [ADDR_BITS-1:0] addr_q [QUEUE_DEPTH];
	logic [LINE_SIZE-1:0] line_q [QUEUE_DEPTH];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic [IDX_BITS-1:0] word_idx;
	logic                head_active;
	logic                empty;
	logic                push_ok;
	logic                pop;
	logic                head_new;

	assign empty    = (count == '0);
	assign req_full = (count == CNT_BITS'(QUEUE_DEPTH));
	// Pushes into a full queue are dropped
	assign push_ok  = req_push && !req_full;
	assign pop      = tx_done && !empty;

	// Head is only shown once the controller has left STARTUP
	always_comb begin
		if (ready && !empty) begin
			op = op_q[rd_ptr];
		end else begin
			op = IDLE;
		end
	end

	assign head_addr = addr_q[rd_ptr];
	assign wr_word   = line_q[rd_ptr][word_idx*WORD_SIZE +: WORD_SIZE];
	// First cycle a head is on op
	assign head_new  = (op != IDLE) && !head_active;

	always_ff @(posedge clk) begin
		if (push_ok) begin
			op_q[wr_ptr]   <= req_op;
			addr_q[wr_ptr] <= req_addr;
			line_q[wr_ptr] <= req_wline;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			word_idx    <= '0;
			head_active <= 1'b0;
		end else begin
			if (push_ok) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push_ok, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: begin
				end
			endcase
			// Word 0 lines up with the first FILL cycle after dispatch
			if (head_new) begin
				word_idx <= '0;
			end else begin
				word_idx <= (word_idx == IDX_BITS'(WORDS - 1)) ? '0 : word_idx + 1'b1;
			end
			if (pop) begin
				head_active <= 1'b0;
			end else if (head_new) begin
				head_active <= 1'b1;
			end
		end
	end

	// Cache side must watch req_full before pushing
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		req_push |-> !req_full);

endmodule

/* resp_assembler.sv */
`timescale 1ns/1ns

module resp_assembler #(
	parameter int WORD_SIZE = line_cfg_pkg::DEF_WORD_SIZE,
	parameter int LINE_SIZE = line_cfg_pkg::DEF_LINE_SIZE,
	parameter int ADDR_BITS = line_cfg_pkg::DEF_ADDR_BITS
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 rd_valid,
	input  logic                 tx_done,
	input  logic [WORD_SIZE-1:0] rd_word,
	input  logic [ADDR_BITS-1:0] head_addr,
	output logic                 resp_valid,
	output logic [ADDR_BITS-1:0] resp_addr,
	output logic [LINE_SIZE-1:0] resp_line
);
	// Next drained word starts a new line
	logic first_word;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			resp_valid <= 1'b0;
			first_word <= 1'b1;
		end else begin
			// Last word seen so the line is complete one cycle later
			resp_valid <= rd_valid && tx_done;
			if (rd_valid) begin
				first_word <= tx_done;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_valid) begin
			// Same shift order as the controller fill
			resp_line <= {rd_word, resp_line[LINE_SIZE-1:WORD_SIZE]};
			if (first_word) begin
				resp_addr <= head_addr;
			end
		end
	end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int PERIOD       = 4,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst_n
);
	// Free running clock
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset held over the first rising edges and released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

/* tb_mem_subsys.sv */
`timescale 1ns/1ns

module tb_mem_subsys;
	import mem_ops_pkg::*;
	import line_cfg_pkg::*;

	localparam int WORD_SIZE     = DEF_WORD_SIZE;
	localparam int LINE_SIZE     = DEF_LINE_SIZE;
	localparam int ADDR_BITS     = DEF_ADDR_BITS;
	localparam int QUEUE_DEPTH   = DEF_QUEUE_DEPTH;
	localparam int WORDS         = LINE_SIZE / WORD_SIZE;
	localparam int MAX_ENTRIES   = 64;
	// Idle cycles before mem_init and after the last completion
	localparam int SETTLE_CYCLES = 10;

	logic                 clk;
	logic                 rst_n;
	logic                 mem_init;
	logic                 req_push;
	mem_opcode            req_op;
	logic [ADDR_BITS-1:0] req_addr;
	logic [LINE_SIZE-1:0] req_wline;
	logic                 req_full;
	logic                 resp_valid;
	logic [ADDR_BITS-1:0] resp_addr;
	logic [LINE_SIZE-1:0] resp_line;
	logic                 mem_rd_req;
	logic [ADDR_BITS-1:0] mem_addr;
	logic                 mem_rd_valid;
	logic [LINE_SIZE-1:0] mem_rd_data;
	logic                 mem_wr_ready;
	logic                 mem_wr_en;
	logic [LINE_SIZE-1:0] mem_wr_data;

	// Trace contents in push order
	mem_opcode            trace_op   [MAX_ENTRIES];
	logic [ADDR_BITS-1:0] trace_addr [MAX_ENTRIES];
	logic [LINE_SIZE-1:0] trace_line [MAX_ENTRIES];
	int                   n_entries;

	// Host memory model, written lines only
	logic [ADDR_BITS-1:0] model_addr [MAX_ENTRIES];
	logic [LINE_SIZE-1:0] model_line [MAX_ENTRIES];
	int                   model_count;
	logic                 rd_req_seen;
	logic [ADDR_BITS-1:0] rd_req_addr;
	int                   rd_wait;
	int                   wr_phase_left;
	int                   low_len;
	integer               seed;

	// Progress counters
	int done_count;
	int cycle_count;
	int cycle_limit;

	tb_clock_gen #(.PERIOD(4), .RESET_CYCLES(3)) tb_clock_gen_inst (
		.clk(clk), .rst_n(rst_n)
	);

	mem_subsys_top #(
		.WORD_SIZE(WORD_SIZE), .LINE_SIZE(LINE_SIZE),
		.ADDR_BITS(ADDR_BITS), .QUEUE_DEPTH(QUEUE_DEPTH)
	) mem_subsys_top_inst (
		.clk(clk), .rst_n(rst_n), .mem_init(mem_init),
		.req_push(req_push), .req_op(req_op), .req_addr(req_addr),
		.req_wline(req_wline), .req_full(req_full),
		.resp_valid(resp_valid), .resp_addr(resp_addr), .resp_line(resp_line),
		.mem_rd_req(mem_rd_req), .mem_addr(mem_addr), .mem_rd_valid(mem_rd_valid),
		.mem_rd_data(mem_rd_data), .mem_wr_ready(mem_wr_ready),
		.mem_wr_en(mem_wr_en), .mem_wr_data(mem_wr_data)
	);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1, "Run stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [LINE_SIZE-1:0] expected,
			input logic [LINE_SIZE-1:0] actual);
		if (expected !== actual) begin
			$display("Mismatch %s expected %h actual %h", name, expected, actual);
			$display("tests failed");
			$fatal(1, "Run stopped on the first error");
		end
	endtask

	// Unwritten lines hold their own address in every word
	function automatic logic [LINE_SIZE-1:0] default_line(input logic [ADDR_BITS-1:0] addr);
		return {WORDS{addr}};
	endfunction

	function automatic logic [LINE_SIZE-1:0] model_read(input logic [ADDR_BITS-1:0] addr);
		logic [LINE_SIZE-1:0] line;
		int i;
		line = default_line(addr);
		for (i = 0; i < model_count; i++) begin
			if (model_addr[i] == addr) begin
				line = model_line[i];
			end
		end
		return line;
	endfunction

	task automatic store_line(input logic [ADDR_BITS-1:0] addr,
			input logic [LINE_SIZE-1:0] line);
		int i;
		int slot;
		slot = model_count;
		for (i = 0; i < model_count; i++) begin
			if (model_addr[i] == addr) begin
				slot = i;
			end
		end
		model_addr[slot] = addr;
		model_line[slot] = line;
		if (slot == model_count) begin
			model_count++;
		end
	endtask

	// Tokens are op letter, line address, line value
	task automatic read_trace();
		int fd;
		int code;
		logic [7:0] tok;
		logic [ADDR_BITS-1:0] addr;
		logic [LINE_SIZE-1:0] line;
		logic [8*160-1:0] rest;
		fd = $fopen("mem_subsys_trace.txt", "r");
		if (fd == 0) begin
			report_failure("Could not open the trace file mem_subsys_trace.txt");
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", tok);
				if (code == 1 && tok == "#") begin
					code = $fgets(rest, fd);
				end else if (code == 1) begin
					code = $fscanf(fd, "%h %h", addr, line);
					if (code != 2 || (tok != "W" && tok != "R") || n_entries >= MAX_ENTRIES) begin
						report_failure("The trace file holds a line that cannot be parsed");
					end else begin
						trace_op[n_entries]   = (tok == "W") ? WRITE : READ;
						trace_addr[n_entries] = addr;
						trace_line[n_entries] = line;
						n_entries++;
					end
				end
			end
			$fclose(fd);
		end
		// First entry must be a write so that its strobe marks the first pop
		if (n_entries <= QUEUE_DEPTH || trace_op[0] != WRITE) begin
			report_failure("The trace must start with a write and hold more than a full queue");
		end
	endtask

	// One push pulse, held back while the queue is full
	task automatic push_request(input int idx);
		@(negedge clk);
		req_push = 1'b0;
		while (req_full) begin
			@(negedge clk);
		end
		req_push  = 1'b1;
		req_op    = trace_op[idx];
		req_addr  = trace_addr[idx];
		req_wline = (trace_op[idx] == WRITE) ? trace_line[idx] : '0;
	endtask

	task automatic check_write();
		if (done_count >= n_entries) begin
			report_failure("Host write seen after every trace request had completed");
		end else begin
			check_value("write order", trace_op[done_count], WRITE);
			check_value("write address", trace_addr[done_count], mem_addr);
			check_value("write line", trace_line[done_count], mem_wr_data);
			done_count++;
		end
	endtask

	task automatic check_response();
		if (done_count >= n_entries) begin
			report_failure("Read response seen after every trace request had completed");
		end else begin
			check_value("response order", trace_op[done_count], READ);
			check_value("response address", trace_addr[done_count], resp_addr);
			check_value("response line", trace_line[done_count], resp_line);
			done_count++;
		end
	endtask

	// Host read goes out for the request that completes next
	task automatic check_read_request();
		if (done_count >= n_entries) begin
			report_failure("Host read request seen after every trace request had completed");
		end else begin
			check_value("read request order", trace_op[done_count], READ);
			check_value("read request address", trace_addr[done_count], mem_addr);
		end
	endtask

	// Bus checker, sampled on the rising edge
	always @(posedge clk) begin
		if (rst_n) begin
			if (!mem_init) begin
				check_value("host read before init", 0, mem_rd_req);
				check_value("host write before init", 0, mem_wr_en);
				check_value("response before init", 0, resp_valid);
			end
			if (resp_valid) begin
				check_response();
			end
			if (mem_wr_en) begin
				check_write();
			end
			if (mem_rd_req) begin
				check_read_request();
			end
		end
	end

	// Host model capture
	always @(posedge clk) begin
		if (mem_rd_req) begin
			rd_req_seen = 1'b1;
			rd_req_addr = mem_addr;
		end
		if (mem_wr_en) begin
			store_line(mem_addr, mem_wr_data);
		end
	end

	// Host model drive on the falling edge
	always @(negedge clk) begin
		mem_rd_valid = 1'b0;
		if (rd_req_seen) begin
			rd_req_seen = 1'b0;
			rd_wait     = 1 + {$random(seed)} % 5;
		end
		if (rd_wait == 1) begin
			mem_rd_valid = 1'b1;
			mem_rd_data  = model_read(rd_req_addr);
		end
		if (rd_wait > 0) begin
			rd_wait--;
		end
		// Write ready alternates low 0 to 4 cycles and high 2 to 5 cycles
		if (wr_phase_left > 0) begin
			wr_phase_left--;
		end
		if (wr_phase_left == 0) begin
			if (mem_wr_ready) begin
				low_len = {$random(seed)} % 5;
				if (low_len > 0) begin
					mem_wr_ready  = 1'b0;
					wr_phase_left = low_len;
				end else begin
					wr_phase_left = 2 + {$random(seed)} % 4;
				end
			end else begin
				mem_wr_ready  = 1'b1;
				wr_phase_left = 2 + {$random(seed)} % 4;
			end
		end
	end

	// Watchdog
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			report_failure("Timeout with trace requests still not completed");
		end
	end

	initial begin
		int idx;
		seed          = 22;
		mem_init      = 1'b0;
		req_push      = 1'b0;
		req_op        = IDLE;
		req_addr      = '0;
		req_wline     = '0;
		mem_rd_valid  = 1'b0;
		mem_rd_data   = '0;
		mem_wr_ready  = 1'b0;
		rd_req_seen   = 1'b0;
		rd_req_addr   = '0;
		rd_wait       = 0;
		wr_phase_left = 0;
		model_count   = 0;
		n_entries     = 0;
		done_count    = 0;
		cycle_count   = 0;
		cycle_limit   = 100;
		read_trace();
		cycle_limit = 40 * n_entries + 100;
		wait (rst_n === 1'b1);
		// Fill the queue while host memory is still down
		for (idx = 0; idx < QUEUE_DEPTH; idx++) begin
			push_request(idx);
		end
		@(negedge clk);
		req_push = 1'b0;
		check_value("queue full before init", 1, req_full);
		repeat (SETTLE_CYCLES) @(negedge clk);
		mem_init = 1'b1;
		// Queue stays full until the first write strobe pops its head
		@(negedge clk);
		while (done_count == 0) begin
			check_value("queue full before first completion", 1, req_full);
			@(negedge clk);
		end
		check_value("queue full after first completion", 0, req_full);
		for (idx = QUEUE_DEPTH; idx < n_entries; idx++) begin
			push_request(idx);
		end
		@(negedge clk);
		req_push = 1'b0;
		while (done_count < n_entries) begin
			@(negedge clk);
		end
		// Quiet tail catches stray responses
		repeat (SETTLE_CYCLES) @(negedge clk);
		$display("all tests passed");
		$finish;
	end

endmodule
